// File: common/ext_mem_cfg.svh
`ifndef EXT_MEM_CFG_SVH
`define EXT_MEM_CFG_SVH

// Word address width of the external memory
`define EXT_MEM_ADDR_W 12

// Cache index width
// Both caches use this, 16 lines each by default
`define EXT_MEM_IDX_W 4

// Outstanding requests allowed on the external port
`define EXT_MEM_CREDITS 4

`endif

// File: common/ext_mem_pkg.sv
`include "ext_mem_cfg.svh"

package ext_mem_pkg;

   // Basic payload types
   typedef logic [31:0]                 data_t;   // One memory word
   typedef logic [`EXT_MEM_ADDR_W-1:0]  addr_t;   // Word address
   typedef logic [3:0]                  strb_t;   // Byte strobe

   // Data port opcodes
   typedef enum logic [1:0] {
      D_READ  = 2'd0,
      D_WRITE = 2'd1,
      D_INVAL = 2'd2   // Clear every line
   } d_op_e;

   // Cache controller states
   // Shared by both caches, C_INVAL only used by dcache
   typedef enum logic [2:0] {
      C_IDLE   = 3'd0,
      C_LOOKUP = 3'd1,   // Tag compare
      C_MISS   = 3'd2,   // Drop victim, raise back-end req
      C_WAIT   = 3'd3,   // Back-end req held until ack
      C_INVAL  = 3'd4    // Walk through all lines
   } cache_state_e;

   // Tag of the external response owner
   typedef enum logic {
      SRC_I = 1'b0,
      SRC_D = 1'b1
   } src_e;

endpackage

// File: common/mem_bus_if.sv
// Cache back-end bus, request held until a one cycle ack
interface mem_bus_if import ext_mem_pkg::*; ();

   logic  req;     // Request valid
   logic  we;      // Write when high
   addr_t addr;
   data_t wdata;
   strb_t wstrb;   // Zero on reads
   data_t rdata;   // Valid with ack on reads
   logic  ack;

   // Cache side
   modport master (
      output req, we, addr, wdata, wstrb,
      input  rdata, ack
   );

   // Merge unit side
   modport slave (
      input  req, we, addr, wdata, wstrb,
      output rdata, ack
   );

endinterface

// File: src/icache.sv
`include "ext_mem_cfg.svh"

module icache import ext_mem_pkg::*; (
   input  logic      clk_i,
   input  logic      arst_i,
   input  logic      i_req_i,
   input  addr_t     i_addr_i,
   output data_t     i_rdata_o,
   output logic      i_ack_o,
   mem_bus_if.master be
);

   localparam int LINES = 2 ** `EXT_MEM_IDX_W;
   localparam int TAG_W = `EXT_MEM_ADDR_W - `EXT_MEM_IDX_W;

   cache_state_e state_q;
   logic [LINES-1:0] valid_q;            // One bit per line
   logic [TAG_W-1:0] tag_q [LINES];
   data_t            data_q [LINES];
   data_t            rdata_q;
   logic             ack_q;
   logic             be_req_q;

   logic [`EXT_MEM_IDX_W-1:0] idx;
   logic [TAG_W-1:0]          tag;
   logic                      hit;
   logic                      fill;

   // Address split, fields are held by the requester
   assign idx  = i_addr_i[`EXT_MEM_IDX_W-1:0];
   assign tag  = i_addr_i[`EXT_MEM_ADDR_W-1:`EXT_MEM_IDX_W];
   assign hit  = valid_q[idx] && (tag_q[idx] == tag);
   assign fill = (state_q == C_WAIT) && be.ack;   // Refill word arrives

   // Back-end is read only
   assign be.req   = be_req_q;
   assign be.we    = 1'b0;
   assign be.addr  = i_addr_i;
   assign be.wdata = '0;
   assign be.wstrb = '0;

   assign i_rdata_o = rdata_q;
   assign i_ack_o   = ack_q;

   // Controller
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q  <= C_IDLE;
         valid_q  <= '0;
         ack_q    <= 1'b0;
         be_req_q <= 1'b0;
      end else begin
         ack_q <= 1'b0;   // Ack lasts one cycle
         case (state_q)
            C_IDLE: begin
               // Req still high during our own ack cycle
               if (i_req_i && !ack_q) begin
                  state_q <= C_LOOKUP;
               end
            end
            C_LOOKUP: begin
               if (hit) begin
                  ack_q   <= 1'b1;
                  state_q <= C_IDLE;
               end else begin
                  state_q <= C_MISS;
               end
            end
            C_MISS: begin
               valid_q[idx] <= 1'b0;   // Old line is gone
               be_req_q     <= 1'b1;
               state_q      <= C_WAIT;
            end
            C_WAIT: begin
               if (be.ack) begin
                  be_req_q     <= 1'b0;
                  valid_q[idx] <= 1'b1;
                  ack_q        <= 1'b1;
                  state_q      <= C_IDLE;
               end
            end
            default: state_q <= C_IDLE;
         endcase
      end
   end

   // Line arrays and read data
   always_ff @(posedge clk_i) begin
      if (state_q == C_LOOKUP && hit) begin
         rdata_q <= data_q[idx];
      end
      if (fill) begin
         tag_q[idx]  <= tag;
         data_q[idx] <= be.rdata;
         rdata_q     <= be.rdata;   // Forward refill word
      end
   end

endmodule

// File: src/dcache.sv
`include "ext_mem_cfg.svh"

module dcache import ext_mem_pkg::*; (
   input  logic      clk_i,
   input  logic      arst_i,
   input  logic      d_req_i,
   input  d_op_e     d_op_i,
   input  addr_t     d_addr_i,
   input  data_t     d_wdata_i,
   input  strb_t     d_wstrb_i,
   output data_t     d_rdata_o,
   output logic      d_ack_o,
   mem_bus_if.master be
);

   localparam int LINES = 2 ** `EXT_MEM_IDX_W;
   localparam int TAG_W = `EXT_MEM_ADDR_W - `EXT_MEM_IDX_W;

   cache_state_e state_q;
   logic [LINES-1:0]          valid_q;
   logic [`EXT_MEM_IDX_W-1:0] inv_idx_q;   // Invalidate walk
   logic [TAG_W-1:0]          tag_q [LINES];
   data_t                     data_q [LINES];
   data_t                     rdata_q;
   logic                      ack_q;
   logic                      be_req_q;

   logic [`EXT_MEM_IDX_W-1:0] idx;
   logic [TAG_W-1:0]          tag;
   logic                      hit;
   logic                      is_wr;
   logic                      be_done;

   // Byte merge of a write into a cached word
   function automatic data_t merge_bytes(data_t old_w, data_t new_w, strb_t strb);
      data_t res;
      res = old_w;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

   assign idx     = d_addr_i[`EXT_MEM_IDX_W-1:0];
   assign tag     = d_addr_i[`EXT_MEM_ADDR_W-1:`EXT_MEM_IDX_W];
   assign hit     = valid_q[idx] && (tag_q[idx] == tag);
   assign is_wr   = (d_op_i == D_WRITE);
   assign be_done = (state_q == C_WAIT) && be.ack;

   // Write through, strobe only on writes
   assign be.req   = be_req_q;
   assign be.we    = is_wr;
   assign be.addr  = d_addr_i;
   assign be.wdata = d_wdata_i;
   assign be.wstrb = is_wr ? d_wstrb_i : '0;

   assign d_rdata_o = rdata_q;
   assign d_ack_o   = ack_q;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q   <= C_IDLE;
         valid_q   <= '0;
         inv_idx_q <= '0;
         ack_q     <= 1'b0;
         be_req_q  <= 1'b0;
      end else begin
         ack_q <= 1'b0;
         case (state_q)
            C_IDLE: begin
               if (d_req_i && !ack_q) begin
                  inv_idx_q <= '0;
                  state_q   <= (d_op_i == D_INVAL) ? C_INVAL : C_LOOKUP;
               end
            end
            C_LOOKUP: begin
               if (is_wr) begin   // No write allocate
                  be_req_q <= 1'b1;
                  state_q  <= C_WAIT;
               end else if (hit) begin
                  ack_q   <= 1'b1;
                  state_q <= C_IDLE;
               end else begin
                  state_q <= C_MISS;
               end
            end
            C_MISS: begin
               valid_q[idx] <= 1'b0;
               be_req_q     <= 1'b1;
               state_q      <= C_WAIT;
            end
            C_WAIT: begin
               if (be.ack) begin
                  be_req_q <= 1'b0;
                  if (!is_wr) valid_q[idx] <= 1'b1;   // Refilled
                  ack_q   <= 1'b1;
                  state_q <= C_IDLE;
               end
            end
            C_INVAL: begin
               valid_q[inv_idx_q] <= 1'b0;
               inv_idx_q          <= inv_idx_q + 1'b1;
               if (&inv_idx_q) begin   // Last line
                  ack_q   <= 1'b1;
                  state_q <= C_IDLE;
               end
            end
            default: state_q <= C_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == C_LOOKUP && hit && !is_wr) rdata_q <= data_q[idx];
      if (be_done && !is_wr) begin
         tag_q[idx]  <= tag;
         data_q[idx] <= be.rdata;
         rdata_q     <= be.rdata;
      end
      // Keep a hit line in step with memory
      if (be_done && is_wr && hit) begin
         data_q[idx] <= merge_bytes(data_q[idx], d_wdata_i, d_wstrb_i);
      end
   end

endmodule

// File: src/bus_merge.sv
`include "ext_mem_cfg.svh"

module bus_merge import ext_mem_pkg::*; (
   input  logic     clk_i,
   input  logic     arst_i,
   mem_bus_if.slave i_be,
   mem_bus_if.slave d_be,
   output logic     mem_req_valid_o,
   output logic     mem_req_we_o,
   output addr_t    mem_req_addr_o,
   output data_t    mem_req_wdata_o,
   output strb_t    mem_req_wstrb_o,
   input  logic     mem_credit_i,
   input  logic     mem_rsp_valid_i,
   input  data_t    mem_rsp_rdata_i
);

   localparam int DEPTH = `EXT_MEM_CREDITS;
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   logic             grant_vld_q;    // Granted, not yet issued
   src_e             grant_src_q;
   logic             i_busy_q;       // In flight on the external port
   logic             d_busy_q;
   logic [CNT_W-1:0] credit_cnt_q;
   src_e             tag_mem [DEPTH];   // Owner of each outstanding request
   logic [PTR_W-1:0] tag_wr_q;
   logic [PTR_W-1:0] tag_rd_q;

   logic i_pend;
   logic d_pend;
   logic issue;
   logic grant_free;
   logic sel_d;
   src_e head;

   function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   // A master already granted or in flight is not pending
   assign i_pend = i_be.req && !i_busy_q && !(grant_vld_q && grant_src_q == SRC_I);
   assign d_pend = d_be.req && !d_busy_q && !(grant_vld_q && grant_src_q == SRC_D);
   assign issue      = grant_vld_q && (credit_cnt_q != '0);   // Stalls at zero credits
   assign grant_free = !grant_vld_q || issue;
   assign sel_d      = (grant_src_q == SRC_D);
   assign head       = tag_mem[tag_rd_q];

   assign mem_req_valid_o = issue;
   assign mem_req_we_o    = sel_d ? d_be.we    : i_be.we;
   assign mem_req_addr_o  = sel_d ? d_be.addr  : i_be.addr;
   assign mem_req_wdata_o = sel_d ? d_be.wdata : i_be.wdata;
   assign mem_req_wstrb_o = sel_d ? d_be.wstrb : i_be.wstrb;

   // In order responses go to the oldest tag
   assign i_be.ack   = mem_rsp_valid_i && (head == SRC_I);
   assign d_be.ack   = mem_rsp_valid_i && (head == SRC_D);
   assign i_be.rdata = mem_rsp_rdata_i;
   assign d_be.rdata = mem_rsp_rdata_i;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         grant_vld_q  <= 1'b0;
         grant_src_q  <= SRC_I;
         i_busy_q     <= 1'b0;
         d_busy_q     <= 1'b0;
         credit_cnt_q <= CNT_W'(DEPTH);
         tag_wr_q     <= '0;
         tag_rd_q     <= '0;
      end else begin
         if (issue) grant_vld_q <= 1'b0;
         if (grant_free && d_pend) begin   // Data cache first
            grant_vld_q <= 1'b1;
            grant_src_q <= SRC_D;
         end else if (grant_free && i_pend) begin
            grant_vld_q <= 1'b1;
            grant_src_q <= SRC_I;
         end
         if (issue && !sel_d) i_busy_q <= 1'b1;
         if (issue && sel_d)  d_busy_q <= 1'b1;
         if (i_be.ack) i_busy_q <= 1'b0;
         if (d_be.ack) d_busy_q <= 1'b0;
         credit_cnt_q <= credit_cnt_q - CNT_W'(issue) + CNT_W'(mem_credit_i);
         if (issue) tag_wr_q <= ptr_inc(tag_wr_q);
         if (mem_rsp_valid_i) tag_rd_q <= ptr_inc(tag_rd_q);
      end
   end

   always_ff @(posedge clk_i) begin
      if (issue) tag_mem[tag_wr_q] <= grant_src_q;
   end

endmodule

// File: src/ext_mem.sv
module ext_mem import ext_mem_pkg::*; (
   input  logic  clk_i,
   input  logic  arst_i,

   // Instruction port
   input  logic  i_req_i,
   input  addr_t i_addr_i,
   output data_t i_rdata_o,
   output logic  i_ack_o,

   // Data port
   input  logic  d_req_i,
   input  d_op_e d_op_i,
   input  addr_t d_addr_i,
   input  data_t d_wdata_i,
   input  strb_t d_wstrb_i,
   output data_t d_rdata_o,
   output logic  d_ack_o,

   // External memory, credit based
   output logic  mem_req_valid_o,
   output logic  mem_req_we_o,
   output addr_t mem_req_addr_o,
   output data_t mem_req_wdata_o,
   output strb_t mem_req_wstrb_o,
   input  logic  mem_credit_i,
   input  logic  mem_rsp_valid_i,
   input  data_t mem_rsp_rdata_i
);

   // Cache back-ends into the merge unit
   mem_bus_if i_be ();
   mem_bus_if d_be ();

   icache icache_i (
      .clk_i     (clk_i),
      .arst_i    (arst_i),
      .i_req_i   (i_req_i),
      .i_addr_i  (i_addr_i),
      .i_rdata_o (i_rdata_o),
      .i_ack_o   (i_ack_o),
      .be        (i_be.master)
   );

   dcache dcache_i (
      .clk_i     (clk_i),
      .arst_i    (arst_i),
      .d_req_i   (d_req_i),
      .d_op_i    (d_op_i),
      .d_addr_i  (d_addr_i),
      .d_wdata_i (d_wdata_i),
      .d_wstrb_i (d_wstrb_i),
      .d_rdata_o (d_rdata_o),
      .d_ack_o   (d_ack_o),
      .be        (d_be.master)
   );

   bus_merge bus_merge_i (
      .clk_i           (clk_i),
      .arst_i          (arst_i),
      .i_be            (i_be.slave),
      .d_be            (d_be.slave),
      .mem_req_valid_o (mem_req_valid_o),
      .mem_req_we_o    (mem_req_we_o),
      .mem_req_addr_o  (mem_req_addr_o),
      .mem_req_wdata_o (mem_req_wdata_o),
      .mem_req_wstrb_o (mem_req_wstrb_o),
      .mem_credit_i    (mem_credit_i),
      .mem_rsp_valid_i (mem_rsp_valid_i),
      .mem_rsp_rdata_i (mem_rsp_rdata_i)
   );

endmodule

// File: tests/ext_mem_asserts.sv
`include "ext_mem_cfg.svh"

module ext_mem_asserts #(
   parameter int CNT_W = $clog2(`EXT_MEM_CREDITS + 1)
) (
   input logic             clk_i,
   input logic             arst_i,
   input logic [CNT_W-1:0] credit_cnt_i,
   input logic             issue_i,
   input logic             credit_i,
   input logic             mem_rsp_valid_i,
   input logic             i_req_i,
   input logic             i_ack_i,
   input logic             d_req_i,
   input logic             d_ack_i
);

   int err_cnt = 0;   // Failures so far, polled by the testbench
   int spent_q;       // Credits taken and not yet returned, seen at the port
   int occ_q;         // Requests still waiting for a response

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         spent_q <= 0;
         occ_q   <= 0;
      end else begin
         spent_q <= spent_q + int'(issue_i) - int'(credit_i);
         occ_q   <= occ_q + int'(issue_i) - int'(mem_rsp_valid_i);
      end
   end

   credit_max: assert property (@(posedge clk_i) disable iff (arst_i)
      credit_cnt_i <= `EXT_MEM_CREDITS)
      else begin
         err_cnt++;
         $error("credit count above its limit");
      end

   // Port side count must still hold a credit
   issue_needs_credit: assert property (@(posedge clk_i) disable iff (arst_i)
      issue_i |-> spent_q < `EXT_MEM_CREDITS)
      else begin
         err_cnt++;
         $error("request issued with no credit");
      end

   // Push into a full tag FIFO without a pop
   tag_no_overflow: assert property (@(posedge clk_i) disable iff (arst_i)
      (occ_q <= `EXT_MEM_CREDITS) &&
      !(issue_i && !mem_rsp_valid_i && occ_q == `EXT_MEM_CREDITS))
      else begin
         err_cnt++;
         $error("tag FIFO overflow");
      end

   i_ack_with_req: assert property (@(posedge clk_i) disable iff (arst_i)
      i_ack_i |-> i_req_i)
      else begin
         err_cnt++;
         $error("icache back-end ack with no req");
      end

   d_ack_with_req: assert property (@(posedge clk_i) disable iff (arst_i)
      d_ack_i |-> d_req_i)
      else begin
         err_cnt++;
         $error("dcache back-end ack with no req");
      end

endmodule

bind bus_merge ext_mem_asserts ext_mem_asserts_i (
   .clk_i           (clk_i),
   .arst_i          (arst_i),
   .credit_cnt_i    (credit_cnt_q),
   .issue_i         (mem_req_valid_o),
   .credit_i        (mem_credit_i),
   .mem_rsp_valid_i (mem_rsp_valid_i),
   .i_req_i         (i_be.req),
   .i_ack_i         (i_be.ack),
   .d_req_i         (d_be.req),
   .d_ack_i         (d_be.ack)
);

// File: tests/ext_mem_tb.sv
`include "ext_mem_cfg.svh"

module ext_mem_tb import ext_mem_pkg::*; ();

   localparam int WORDS   = 2 ** `EXT_MEM_ADDR_W;
   localparam int LINES   = 2 ** `EXT_MEM_IDX_W;
   localparam int TIMEOUT = 200;   // Cycles per wait
   localparam int MIX_N   = 30;    // Ops per port in the mixed phase

   logic  clk_i;
   logic  arst_i;
   logic  i_req_i;
   addr_t i_addr_i;
   data_t i_rdata_o;
   logic  i_ack_o;
   logic  d_req_i;
   d_op_e d_op_i;
   addr_t d_addr_i;
   data_t d_wdata_i;
   strb_t d_wstrb_i;
   data_t d_rdata_o;
   logic  d_ack_o;
   logic  mem_req_valid_o;
   logic  mem_req_we_o;
   addr_t mem_req_addr_o;
   data_t mem_req_wdata_o;
   strb_t mem_req_wstrb_o;
   logic  mem_credit_i;
   logic  mem_rsp_valid_i;
   data_t mem_rsp_rdata_i;

   data_t mem [WORDS];         // Model array, changed by bus writes
   data_t gold [WORDS];        // Expected memory contents
   logic  sh_valid [LINES];    // Shadow of the data cache lines
   addr_t sh_addr [LINES];
   data_t sh_data [LINES];
   data_t i_exp_q [$];
   data_t d_exp_q [$];
   bit    d_chk_q [$];         // Reads carry data, writes and inval do not
   data_t rsp_data_q [$];
   int    rsp_due_q [$];       // Cycle of each response
   logic [31:0] lfsr_q = 32'h1f38;
   int    cyc;
   int    owed;                // Credits not yet returned
   int    hold_cnt;
   int    due_c;
   bit    rsp_last;
   bit    hold_en;
   bit    started;             // First front-end request driven
   addr_t a;
   data_t wd;
   strb_t st;
   addr_t i_list [MIX_N];
   addr_t d_list [MIX_N];
   d_op_e op_list [MIX_N];
   data_t wd_list [MIX_N];
   strb_t st_list [MIX_N];

   ext_mem ext_mem_i (.*);

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] take_bits(int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++) begin
         lfsr_q = lfsr_next(lfsr_q);   // One step per bit
         r      = {r[30:0], lfsr_q[0]};
      end
      return r;
   endfunction

   function automatic data_t merge_word(data_t old_w, data_t new_w, strb_t strb);
      data_t mask;
      mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};   // Byte lanes
      return (old_w & ~mask) | (new_w & mask);
   endfunction

   // Expected read data for either port
   function automatic data_t ref_rdata(src_e src, addr_t addr);
      logic [`EXT_MEM_IDX_W-1:0] idx;
      idx = addr[`EXT_MEM_IDX_W-1:0];
      if (src == SRC_D && sh_valid[idx] && sh_addr[idx] == addr) begin
         return sh_data[idx];   // Cached copy, possibly stale
      end
      return gold[addr];
   endfunction

   task automatic abort(string why);
      $display("%s", why);
      $display("SIMULATION FAILED");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic compare_i_rdata(data_t got, data_t exp);
      if (got !== exp) abort($sformatf("Fail i_rdata_o: got %08h expected %08h", got, exp));
   endtask

   task automatic compare_d_rdata(data_t got, data_t exp);
      if (got !== exp) abort($sformatf("Fail d_rdata_o: got %08h expected %08h", got, exp));
   endtask

   task automatic compare_strb(strb_t got, strb_t exp);
      if (got !== exp) begin
         abort($sformatf("Fail mem_req_wstrb_o: got %h expected %h", got, exp));
      end
   endtask

   task automatic compare_mem_word(addr_t addr, data_t got, data_t exp);
      if (got !== exp) begin
         abort($sformatf("Fail mem[%03h]: got %08h expected %08h", addr, got, exp));
      end
   endtask

   task automatic i_access(addr_t addr);
      int n;
      i_exp_q.push_back(ref_rdata(SRC_I, addr));
      started  = 1'b1;
      i_req_i  = 1'b1;
      i_addr_i = addr;
      n = 0;
      do begin
         @(posedge clk_i);
         #1;
         n++;
      end while (!i_ack_o && n < TIMEOUT);
      if (!i_ack_o) abort("Timeout waiting for the instruction ack");
      i_req_i = 1'b0;
   endtask

   task automatic d_access(d_op_e op, addr_t addr, data_t wdata, strb_t strb);
      int n;
      logic [`EXT_MEM_IDX_W-1:0] idx;
      logic hit;
      idx = addr[`EXT_MEM_IDX_W-1:0];
      hit = sh_valid[idx] && sh_addr[idx] == addr;
      d_chk_q.push_back(op == D_READ);
      d_exp_q.push_back(ref_rdata(SRC_D, addr));
      case (op)
         D_READ: begin
            if (!hit) begin   // Refill replaces the line
               sh_valid[idx] = 1'b1;
               sh_addr[idx]  = addr;
               sh_data[idx]  = gold[addr];
            end
         end
         D_WRITE: begin   // Write through, no allocate
            gold[addr] = merge_word(gold[addr], wdata, strb);
            if (hit) sh_data[idx] = merge_word(sh_data[idx], wdata, strb);
         end
         default: begin
            foreach (sh_valid[k]) sh_valid[k] = 1'b0;
         end
      endcase
      started   = 1'b1;
      d_req_i   = 1'b1;
      d_op_i    = op;
      d_addr_i  = addr;
      d_wdata_i = wdata;
      d_wstrb_i = strb;
      n = 0;
      do begin
         @(posedge clk_i);
         #1;
         n++;
      end while (!d_ack_o && n < TIMEOUT);
      if (!d_ack_o) abort("Timeout waiting for the data ack");
      d_req_i = 1'b0;
   endtask

   // Memory model request side and credit hold, sampled mid-cycle
   always @(negedge clk_i) begin
      if (mem_req_valid_o === 1'b1) begin
         if (mem_req_we_o) begin
            mem[mem_req_addr_o] = merge_word(mem[mem_req_addr_o], mem_req_wdata_o,
                                             mem_req_wstrb_o);
            rsp_data_q.push_back('0);   // Write response has no data
         end else begin
            compare_strb(mem_req_wstrb_o, '0);   // Reads carry no strobe
            rsp_data_q.push_back(mem[mem_req_addr_o]);
         end
         due_c = cyc + 1 + int'(take_bits(2));   // 1 to 4 cycles
         if (rsp_due_q.size() > 0 && due_c <= rsp_due_q[$]) due_c = rsp_due_q[$] + 1;
         rsp_due_q.push_back(due_c);
      end
      if (!hold_en) hold_cnt = 0;
      else if (hold_cnt > 0) hold_cnt--;
      else if (take_bits(3) == 0) hold_cnt = 1 + int'(take_bits(4)) + int'(take_bits(2));
   end

   // Responses in order, credit one cycle later
   always @(posedge clk_i) begin
      cyc++;
      #1;
      mem_rsp_valid_i = 1'b0;
      mem_rsp_rdata_i = '0;
      mem_credit_i    = 1'b0;
      owed += rsp_last;
      rsp_last = 1'b0;
      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin
         void'(rsp_due_q.pop_front());
         mem_rsp_rdata_i = rsp_data_q.pop_front();
         mem_rsp_valid_i = 1'b1;
         rsp_last        = 1'b1;
      end
      if (hold_cnt == 0 && owed > 0) begin   // Withheld while holding
         mem_credit_i = 1'b1;
         owed--;
      end
   end

   // Compare process, acks are stable at the falling edge
   always @(negedge clk_i) begin
      if (ext_mem_i.bus_merge_i.ext_mem_asserts_i.err_cnt != 0) begin
         abort("A bound assertion on bus_merge failed");
      end
      if (!started && (i_ack_o || d_ack_o || mem_req_valid_o)) begin
         abort("Ack or memory request seen before the first request");
      end
      if (i_ack_o === 1'b1) begin
         if (i_exp_q.size() == 0) abort("Instruction ack with no request pending");
         else compare_i_rdata(i_rdata_o, i_exp_q.pop_front());
      end
      if (d_ack_o === 1'b1) begin
         if (d_exp_q.size() == 0) abort("Data ack with no request pending");
         else if (d_chk_q.pop_front()) compare_d_rdata(d_rdata_o, d_exp_q.pop_front());
         else void'(d_exp_q.pop_front());
      end
   end

   initial begin
      arst_i          = 1'b1;
      i_req_i         = 1'b0;
      i_addr_i        = '0;
      d_req_i         = 1'b0;
      d_op_i          = D_READ;
      d_addr_i        = '0;
      d_wdata_i       = '0;
      d_wstrb_i       = '0;
      mem_credit_i    = 1'b0;
      mem_rsp_valid_i = 1'b0;
      mem_rsp_rdata_i = '0;
      for (int w = 0; w < WORDS; w++) begin
         mem[w]  = data_t'(w) * 32'h9e37 + 32'd1;
         gold[w] = mem[w];
      end
      foreach (sh_valid[k]) sh_valid[k] = 1'b0;
      repeat (16) @(posedge clk_i);
      #1;
      arst_i = 1'b0;
      repeat (5) @(posedge clk_i);   // Idle, all quiet
      #1;

      // Instruction reads, lower half, small set so lines hit again
      repeat (40) i_access(addr_t'(take_bits(6)));

      // Strobed writes to the upper half, read back
      for (int k = 0; k < 24; k++) begin
         a = addr_t'(12'h800 + take_bits(5));
         d_access(D_READ, a, '0, '0);   // Gets some lines cached
         a  = addr_t'(12'h800 + take_bits(5));
         wd = take_bits(32);
         st = strb_t'(take_bits(4));
         d_access(D_WRITE, a, wd, st);
         d_access(D_READ, a, '0, '0);
      end

      // Both ports at once under credit back-pressure
      for (int k = 0; k < MIX_N; k++) begin
         i_list[k]  = addr_t'(take_bits(6));
         d_list[k]  = addr_t'(12'h800 + take_bits(5));
         op_list[k] = take_bits(1) ? D_WRITE : D_READ;
         wd_list[k] = take_bits(32);
         st_list[k] = strb_t'(take_bits(4));
      end
      hold_en = 1'b1;
      fork
         for (int k = 0; k < MIX_N; k++) i_access(i_list[k]);
         for (int k = 0; k < MIX_N; k++) d_access(op_list[k], d_list[k], wd_list[k], st_list[k]);
      join
      hold_en = 1'b0;

      // Stale line until invalidate
      a = 12'ha55;
      d_access(D_READ, a, '0, '0);
      gold[a] = ~gold[a];   // Changed behind the cache
      mem[a]  = gold[a];
      d_access(D_READ, a, '0, '0);
      d_access(D_INVAL, a, '0, '0);
      d_access(D_READ, a, '0, '0);

      repeat (2) @(posedge clk_i);   // Last compare at falling edge

      // Every write must have reached memory with its strobe
      for (int w = 0; w < WORDS; w++) compare_mem_word(addr_t'(w), mem[w], gold[w]);

      if (i_exp_q.size() != 0 || d_exp_q.size() != 0 ||
          ext_mem_i.bus_merge_i.ext_mem_asserts_i.err_cnt != 0) begin
         abort("Requests left without a checked ack");
      end else begin
         $display("SIMULATION PASSED");
         $finish;
      end
   end

endmodule

// File: files.f
+incdir+common
common/ext_mem_pkg.sv
common/mem_bus_if.sv
src/icache.sv
src/dcache.sv
src/bus_merge.sv
src/ext_mem.sv
tests/ext_mem_asserts.sv
tests/ext_mem_tb.sv

// File: Bender.yml
package:
  name: ext_mem

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/ext_mem_pkg.sv
      - common/mem_bus_if.sv
      - src/icache.sv
      - src/dcache.sv
      - src/bus_merge.sv
      - src/ext_mem.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/ext_mem_asserts.sv
      - tests/ext_mem_tb.sv
